/* testbench/sfp_io_core_stim.txt */
# kind addr data expect, hex. WR expect is tx_enable, tx_disable, phy_reset. RD data 1 means no reply
# STAT addr is mac_status, data is tx_fault, rxlos, phy_status. MDIO expect is PHY data, bit 16 drop
RD   0000 00000000 00000001
RD   0014 00000000 00000002
RD   0018 00000000 00000000
WR   0000 00000000 00000000
WR   0004 00000003 00000003
WR   0000 00000001 00000007
WR   0008 ffffffff 00000007
RD   0008 00000001 00000000
STAT 01a5 0002c3e1 00000000
RD   0000 00000000 01a50001
RD   0004 00000000 0002c3e1
MDIO 0010 05a3beef 00000000
RD   0014 00000000 00000002
MDIO 0010 0a2e0000 0000c0de
RD   0014 00000000 00000006
RD   0018 00000000 8000c0de
RD   0018 00000000 00000000
MDIO 0010 04211111 00000000
MDIO 0010 05422222 00000000
MDIO 0010 06633333 00000000
MDIO 0010 07844444 00000000
MDIO 0010 04a55555 00000000
MDIO 0010 05c66666 00010000
RD   0014 00000000 0000000a
RD   0014 00000000 00000002

/* all.f */
source/sfp_regs_pkg.sv
source/mdio_pkg.sv
source/mdio_cmd_fifo.sv
source/mdio_shifter.sv
source/sfp_reg_block.sv
source/sfp_io_core.sv
testbench/sfp_io_core_tb.sv

/* testbench/sfp_io_core_tb.sv */
`timescale 1ns/1ps

module sfp_io_core_tb;
  import sfp_regs_pkg::*;
  import mdio_pkg::*;

  localparam int CYCLES_PER_LINE = 600;  // One full MDIO frame plus margin

  logic        bus_clk;
  logic        bus_rst;
  logic        reg_wr_req_i;
  reg_addr_t   reg_wr_addr_i;
  reg_data_t   reg_wr_data_i;
  logic        reg_rd_req_i;
  reg_addr_t   reg_rd_addr_i;
  logic        reg_rd_resp_o;
  reg_data_t   reg_rd_data_o;
  mac_status_t mac_status_i;
  phy_status_t phy_status_i;
  logic        sfp_rxlos_i;
  logic        sfp_tx_fault_i;
  logic        mac_tx_enable_o;
  logic        phy_reset_o;
  logic        sfp_tx_disable_o;
  logic        mdc_o;
  logic        mdio_o;
  logic        mdio_oe_o;
  logic        mdio_i;

  // Stimulus table, one entry per file line
  logic [63:0] op_kind [$];
  reg_data_t   op_addr [$];
  reg_data_t   op_data [$];
  reg_data_t   op_exp [$];

  // Expected frames in issue order
  mdio_frame_t exp_frame_q [$];
  mdio_frame_t exp_oe_q [$];
  mdio_rdata_t phy_rdata_q [$];  // What the PHY answers, per frame

  mdio_frame_t mon_frame;
  mdio_frame_t mon_oe;
  int          mon_bit = 0;   // Bit index inside the current frame
  logic        mon_read = 1'b0;

  int   value_errs = 0;
  int   other_errs = 0;
  int   cycle_cnt = 0;
  int   cycle_limit = 0;
  logic loaded = 1'b0;
  logic wr_open = 1'b0;  // Write strobe still high after MDIO pushes

  sfp_io_core u_dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  // ----------------------------------------------------------
  // Compare and report
  // ----------------------------------------------------------
  task automatic check_reg_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_frame(input string name, input mdio_frame_t got, input mdio_frame_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_ctrl(input logic got_en, input phy_ctrl_t got_ctrl,
                            input logic exp_en, input phy_ctrl_t exp_ctrl);
    if ({got_en, got_ctrl} !== {exp_en, exp_ctrl}) begin
      value_errs++;
      $display("CHECK FAILED {mac_tx_enable_o, sfp_tx_disable_o, phy_reset_o} got %h expected %h",
               {got_en, got_ctrl}, {exp_en, exp_ctrl});
    end
  endtask

  task automatic report_error(input string msg);
    other_errs++;
    $display("%0t ns: %s", $time, msg);
  endtask

  // ----------------------------------------------------------
  // Expected MDIO frames
  // ----------------------------------------------------------
  // Wire value, a released turnaround reads as pull-up ones
  function automatic mdio_frame_t build_frame(input mdio_cmd_t cmd, input mdio_rdata_t rdata);
    if (cmd.op == READ)
      return {32'hFFFF_FFFF, 2'b01, cmd.op, cmd.phyad, cmd.regad, 2'b11, rdata};
    else
      return {32'hFFFF_FFFF, 2'b01, cmd.op, cmd.phyad, cmd.regad, 2'b10, cmd.wdata};
  endfunction

  function automatic mdio_frame_t oe_mask(input logic is_read);
    mdio_frame_t m;
    m = '1;
    if (is_read) m[17:0] = '0;  // TA and 16 data bits belong to the PHY
    return m;
  endfunction

  // ----------------------------------------------------------
  // Stimulus file and register port
  // ----------------------------------------------------------
  task automatic load_stim();
    int            fd;
    logic [8*120-1:0] line;
    logic [63:0]   kind;
    reg_data_t     a;
    reg_data_t     d;
    reg_data_t     e;
    fd = $fopen("testbench/sfp_io_core_stim.txt", "r");
    if (fd == 0) begin
      report_error("cannot open the stimulus file");
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if ($sscanf(line, "%s %h %h %h", kind, a, d, e) == 4) begin  // Comments fail here
        op_kind.push_back(kind);
        op_addr.push_back(a);
        op_data.push_back(d);
        op_exp.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(posedge bus_clk);
    reg_wr_req_i  <= 1'b1;
    reg_wr_addr_i <= addr;
    reg_wr_data_i <= data;
    @(posedge bus_clk);
    reg_wr_req_i <= 1'b0;
    @(negedge bus_clk);  // Control outputs settled
  endtask

  task automatic read_reg(input reg_addr_t addr, input logic want_resp, input reg_data_t exp);
    int        lat;
    reg_data_t got;
    lat = 0;
    got = '0;
    @(posedge bus_clk);
    reg_rd_req_i  <= 1'b1;
    reg_rd_addr_i <= addr;
    @(posedge bus_clk);
    reg_rd_req_i <= 1'b0;
    for (int n = 1; n <= 4; n++) begin  // Four-cycle window
      @(negedge bus_clk);
      if (reg_rd_resp_o && lat == 0) begin
        lat = n;
        got = reg_rd_data_o;
      end
    end
    if (!want_resp) begin
      if (lat != 0) report_error($sformatf("read of unmapped address %h got a response", addr));
    end else if (lat == 0) begin
      report_error($sformatf("no read response for address %h", addr));
    end else begin
      if (lat != 2)
        report_error($sformatf("read response for %h came %0d cycles late", addr, lat));
      check_reg_data($sformatf("reg_rd_data_o at %h", addr), got, exp);
    end
  endtask

  // Close a burst of pushes and let every frame finish
  task automatic drain_mdio();
    if (wr_open) begin
      @(posedge bus_clk);
      reg_wr_req_i <= 1'b0;
      wr_open = 1'b0;
    end
    @(negedge bus_clk);
    while (exp_frame_q.size() != 0 || u_dut.shifter_busy) @(negedge bus_clk);
  endtask

  // ----------------------------------------------------------
  // PHY responder and frame monitor
  // ----------------------------------------------------------
  always @(posedge mdc_o) begin
    mon_frame = {mon_frame[MDIO_FRAME_BITS-2:0], mdio_oe_o ? mdio_o : mdio_i};
    mon_oe    = {mon_oe[MDIO_FRAME_BITS-2:0], mdio_oe_o};
    if (mon_bit == 35) mon_read = (mon_frame[1:0] == READ);  // Op is bits 34..35
    // Next data bit goes out now, the shifter samples it on the next rise
    if (mon_read && mon_bit >= 47 && mon_bit < 63 && phy_rdata_q.size() != 0)
      mdio_i <= phy_rdata_q[0][62 - mon_bit];
    else
      mdio_i <= 1'b1;  // Pull-up
    if (mon_bit == MDIO_FRAME_BITS - 1) begin
      if (exp_frame_q.size() == 0) begin
        report_error("MDIO frame seen with no command pending");
      end else begin
        check_frame("mdio frame", mon_frame, exp_frame_q.pop_front());
        check_frame("mdio_oe_o", mon_oe, exp_oe_q.pop_front());
        void'(phy_rdata_q.pop_front());
      end
      mon_bit  = 0;
      mon_read = 1'b0;
    end else begin
      mon_bit++;
    end
  end

  // Watchdog
  initial begin
    wait (loaded);
    while (cycle_cnt <= cycle_limit) begin
      @(posedge bus_clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the test did not finish", cycle_cnt);
    $display("%0d value mismatches, %0d other errors", value_errs, other_errs);
    $display("ERRORS FOUND");
    $finish;
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    logic [63:0] k;
    reg_data_t a;
    reg_data_t d;
    reg_data_t e;
    mdio_cmd_t cmd;
    void'($urandom(32'h61bbed60));
    bus_rst        = 1'b1;
    reg_wr_req_i   = 1'b0;
    reg_wr_addr_i  = '0;
    reg_wr_data_i  = '0;
    reg_rd_req_i   = 1'b0;
    reg_rd_addr_i  = '0;
    mac_status_i   = '0;
    phy_status_i   = '0;
    sfp_rxlos_i    = 1'b0;
    sfp_tx_fault_i = 1'b0;
    mdio_i         = 1'b1;
    load_stim();
    cycle_limit = op_kind.size() * CYCLES_PER_LINE + 1000;
    loaded      = 1'b1;

    repeat (8) @(posedge bus_clk);
    bus_rst <= 1'b0;
    @(negedge bus_clk);
    check_ctrl(mac_tx_enable_o, phy_ctrl_t'({sfp_tx_disable_o, phy_reset_o}), 1'b1, '0);

    for (int i = 0; i < op_kind.size(); i++) begin
      k = op_kind[i];
      a = op_addr[i];
      d = op_data[i];
      e = op_exp[i];
      if (k == "MDIO") begin  // Back to back, no gap
        cmd = mdio_cmd_t'(d[27:0]);
        if (!e[16]) begin  // Bit 16 marks a command the full FIFO drops
          exp_frame_q.push_back(build_frame(cmd, e[15:0]));
          exp_oe_q.push_back(oe_mask(cmd.op == READ));
          phy_rdata_q.push_back(e[15:0]);
        end
        @(posedge bus_clk);
        reg_wr_req_i  <= 1'b1;
        reg_wr_addr_i <= a[13:0];
        reg_wr_data_i <= d;
        wr_open = 1'b1;
      end else begin
        drain_mdio();
        repeat ($urandom_range(1, 6)) @(posedge bus_clk);  // Idle gap
        if (k == "WR") begin
          write_reg(a[13:0], d);
          check_ctrl(mac_tx_enable_o, phy_ctrl_t'({sfp_tx_disable_o, phy_reset_o}),
                     e[2], phy_ctrl_t'(e[1:0]));
        end else if (k == "RD") begin
          read_reg(a[13:0], !d[0], e);
        end else if (k == "STAT") begin
          @(posedge bus_clk);
          mac_status_i   <= mac_status_t'(a[8:0]);
          phy_status_i   <= d[15:0];
          sfp_rxlos_i    <= d[16];
          sfp_tx_fault_i <= d[17];
          repeat (SYNC_STAGES + 1) @(posedge bus_clk);  // Through the synchronizer
        end else begin
          report_error($sformatf("unknown stimulus kind on entry %0d", i));
        end
      end
    end
    drain_mdio();

    $display("%0d value mismatches, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* source/sfp_io_core.sv */
`timescale 1ns/1ps

module sfp_io_core (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  // Register port
  input  logic                      reg_wr_req_i,
  input  sfp_regs_pkg::reg_addr_t   reg_wr_addr_i,
  input  sfp_regs_pkg::reg_data_t   reg_wr_data_i,
  input  logic                      reg_rd_req_i,
  input  sfp_regs_pkg::reg_addr_t   reg_rd_addr_i,
  output logic                      reg_rd_resp_o,
  output sfp_regs_pkg::reg_data_t   reg_rd_data_o,
  // Status from MAC, PHY and SFP cage
  input  sfp_regs_pkg::mac_status_t mac_status_i,
  input  sfp_regs_pkg::phy_status_t phy_status_i,
  input  logic                      sfp_rxlos_i,
  input  logic                      sfp_tx_fault_i,
  // Control
  output logic                      mac_tx_enable_o,
  output logic                      phy_reset_o,
  output logic                      sfp_tx_disable_o,
  // MDIO
  output logic                      mdc_o,
  output logic                      mdio_o,
  output logic                      mdio_oe_o,
  input  logic                      mdio_i
);
  import sfp_regs_pkg::*;
  import mdio_pkg::*;

  phy_ctrl_t   phy_ctrl;
  logic        shifter_busy;
  // Command path, register block to shifter
  logic        cmd_push;
  mdio_cmd_t   cmd_push_data;
  logic        cmd_full;
  logic        cmd_pop;
  mdio_cmd_t   cmd_head;
  logic        cmd_empty;
  // Result path, shifter to register block
  logic        res_push;
  mdio_rdata_t res_push_data;
  logic        res_full;
  logic        res_pop;
  mdio_rdata_t res_head;
  logic        res_empty;

  assign phy_reset_o      = phy_ctrl.phy_reset;
  assign sfp_tx_disable_o = phy_ctrl.tx_disable;

  sfp_reg_block u_reg_block (
    .bus_clk, .bus_rst,
    .reg_wr_req_i, .reg_wr_addr_i, .reg_wr_data_i,
    .reg_rd_req_i, .reg_rd_addr_i, .reg_rd_resp_o, .reg_rd_data_o,
    .mac_status_i, .phy_status_i, .sfp_rxlos_i, .sfp_tx_fault_i,
    .mac_tx_enable_o,
    .phy_ctrl_o     (phy_ctrl),
    .shifter_busy_i (shifter_busy),
    .cmd_full_i     (cmd_full),
    .cmd_empty_i    (cmd_empty),
    .cmd_push_o     (cmd_push),
    .cmd_data_o     (cmd_push_data),
    .res_empty_i    (res_empty),
    .res_data_i     (res_head),
    .res_pop_o      (res_pop)
  );

  mdio_cmd_fifo #(.payload_t(mdio_cmd_t)) u_cmd_fifo (
    .bus_clk, .bus_rst,
    .push_i (cmd_push), .push_data_i (cmd_push_data), .full_o  (cmd_full),
    .pop_i  (cmd_pop),  .pop_data_o  (cmd_head),      .empty_o (cmd_empty)
  );

  mdio_cmd_fifo #(.payload_t(mdio_rdata_t)) u_res_fifo (
    .bus_clk, .bus_rst,
    .push_i (res_push), .push_data_i (res_push_data), .full_o  (res_full),
    .pop_i  (res_pop),  .pop_data_o  (res_head),      .empty_o (res_empty)
  );

  mdio_shifter u_shifter (
    .bus_clk, .bus_rst,
    .cmd_empty_i (cmd_empty),
    .cmd_data_i  (cmd_head),
    .cmd_pop_o   (cmd_pop),
    .res_full_i  (res_full),
    .res_push_o  (res_push),
    .res_data_o  (res_push_data),
    .busy_o      (shifter_busy),
    .mdc_o, .mdio_o, .mdio_oe_o, .mdio_i
  );

endmodule

/* source/sfp_reg_block.sv */
`timescale 1ns/1ps

module sfp_reg_block (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  // Register port
  input  logic                      reg_wr_req_i,
  input  sfp_regs_pkg::reg_addr_t   reg_wr_addr_i,
  input  sfp_regs_pkg::reg_data_t   reg_wr_data_i,
  input  logic                      reg_rd_req_i,
  input  sfp_regs_pkg::reg_addr_t   reg_rd_addr_i,
  output logic                      reg_rd_resp_o,
  output sfp_regs_pkg::reg_data_t   reg_rd_data_o,
  // Status, not in bus_clk domain
  input  sfp_regs_pkg::mac_status_t mac_status_i,
  input  sfp_regs_pkg::phy_status_t phy_status_i,
  input  logic                      sfp_rxlos_i,
  input  logic                      sfp_tx_fault_i,
  // Control
  output logic                      mac_tx_enable_o,
  output sfp_regs_pkg::phy_ctrl_t   phy_ctrl_o,
  // MDIO side
  input  logic                      shifter_busy_i,
  input  logic                      cmd_full_i,
  input  logic                      cmd_empty_i,
  output logic                      cmd_push_o,
  output mdio_pkg::mdio_cmd_t       cmd_data_o,
  input  logic                      res_empty_i,
  input  mdio_pkg::mdio_rdata_t     res_data_i,
  output logic                      res_pop_o
);
  import sfp_regs_pkg::*;
  import mdio_pkg::*;

  typedef struct packed {
    mac_status_t mac;
    phy_status_t phy;
    logic        rxlos;
    logic        tx_fault;
  } status_t;

  status_t   stat_in;
  status_t   sync_q [SYNC_STAGES];
  status_t   stat_s;        // Synchronized copy
  logic      cmd_wr;
  logic      cmd_overflow;  // Sticky, cleared by MDIO_STATUS read
  logic      rd_mapped;
  logic      rd_accept;
  logic      rd_valid_q;    // Readback stage 1
  reg_data_t rd_word;
  reg_data_t rd_data_q;

  // ----------------------------------------------------------
  // Status synchronizers
  // ----------------------------------------------------------
  assign stat_in = '{mac: mac_status_i, phy: phy_status_i,
                     rxlos: sfp_rxlos_i, tx_fault: sfp_tx_fault_i};
  assign stat_s  = sync_q[SYNC_STAGES-1];

  always_ff @(posedge bus_clk) begin
    sync_q[0] <= stat_in;
    for (int i = 1; i < SYNC_STAGES; i++) sync_q[i] <= sync_q[i-1];
  end

  // ----------------------------------------------------------
  // Writes
  // ----------------------------------------------------------
  assign cmd_wr     = reg_wr_req_i && (reg_wr_addr_i == REG_MDIO_CMD);
  assign cmd_push_o = cmd_wr && !cmd_full_i;  // Dropped when full
  assign cmd_data_o = mdio_cmd_t'(reg_wr_data_i[27:0]);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      mac_tx_enable_o <= 1'b1;  // MAC transmits out of reset
      phy_ctrl_o      <= '0;
    end else if (reg_wr_req_i) begin
      case (reg_wr_addr_i)
        REG_MAC_CTRL: mac_tx_enable_o <= reg_wr_data_i[0];
        REG_PHY_CTRL: phy_ctrl_o      <= phy_ctrl_t'(reg_wr_data_i[1:0]);
        default:      ;  // Other addresses ignored
      endcase
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst)
      cmd_overflow <= 1'b0;
    else if (cmd_wr && cmd_full_i)  // Set wins over clear
      cmd_overflow <= 1'b1;
    else if (rd_accept && reg_rd_addr_i == REG_MDIO_STATUS)
      cmd_overflow <= 1'b0;
  end

  // ----------------------------------------------------------
  // Read decode and two-stage readback
  // ----------------------------------------------------------
  always_comb begin
    rd_mapped = 1'b1;
    rd_word   = '0;
    case (reg_rd_addr_i)
      REG_MAC_CTRL:    rd_word = {7'h0, stat_s.mac, 15'h0, mac_tx_enable_o};
      REG_PHY_CTRL:    rd_word = {14'h0, stat_s.tx_fault, stat_s.rxlos, stat_s.phy};
      REG_MDIO_STATUS: rd_word = {28'h0, cmd_overflow, !res_empty_i, cmd_empty_i,
                                  shifter_busy_i};
      REG_MDIO_RDATA:  rd_word = res_empty_i ? '0 : {1'b1, 15'h0, res_data_i};
      default:         rd_mapped = 1'b0;  // No response
    endcase
  end

  // One read in flight at a time
  assign rd_accept = reg_rd_req_i && rd_mapped && !rd_valid_q;
  assign res_pop_o = rd_accept && (reg_rd_addr_i == REG_MDIO_RDATA) && !res_empty_i;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_valid_q    <= 1'b0;
      reg_rd_resp_o <= 1'b0;
    end else begin
      rd_valid_q    <= rd_accept;
      reg_rd_resp_o <= rd_valid_q;
    end
  end

  always_ff @(posedge bus_clk) begin
    rd_data_q     <= rd_word;
    reg_rd_data_o <= rd_data_q;
  end

  // Response is always a single-cycle pulse
  a_resp_pulse : assert property (@(posedge bus_clk) disable iff (bus_rst)
    reg_rd_resp_o |=> !reg_rd_resp_o);

endmodule

/* source/mdio_shifter.sv */
`timescale 1ns/1ps

module mdio_shifter (
  input  logic                  bus_clk,
  input  logic                  bus_rst,
  // Command FIFO side
  input  logic                  cmd_empty_i,
  input  mdio_pkg::mdio_cmd_t   cmd_data_i,
  output logic                  cmd_pop_o,
  // Result FIFO side
  input  logic                  res_full_i,
  output logic                  res_push_o,
  output mdio_pkg::mdio_rdata_t res_data_o,
  output logic                  busy_o,
  // MDIO pins
  output logic                  mdc_o,
  output logic                  mdio_o,
  output logic                  mdio_oe_o,
  input  logic                  mdio_i
);
  import mdio_pkg::*;

  logic                       busy;      // Frame in progress
  logic                       mdc_q;
  logic [MDC_CNT_W-1:0]       div_cnt;   // Position inside one MDC period
  logic [MDIO_BIT_W-1:0]      bit_cnt;   // Bit being sent, 0 = first preamble bit
  logic                       res_pend;  // Read finished, result not yet pushed
  logic                       is_read;
  logic [MDIO_FRAME_BITS-1:0] frame_q;   // MSB goes out first
  logic [MDIO_FRAME_BITS-1:0] frame_d;
  logic [1:0]                 ta_bits;
  mdio_rdata_t                rdata_q;

  // ----------------------------------------------------------
  // Frame build from the head command
  // ----------------------------------------------------------
  always_comb begin
    ta_bits = (cmd_data_i.op == READ) ? 2'b00 : 2'b10;  // PHY owns TA on reads
    frame_d = {32'hFFFF_FFFF,  // Preamble
               2'b01,          // Start
               cmd_data_i.op,
               cmd_data_i.phyad,
               cmd_data_i.regad,
               ta_bits,
               (cmd_data_i.op == READ) ? 16'h0000 : cmd_data_i.wdata};
  end

  // Next frame only when idle and any earlier result has a slot
  assign cmd_pop_o  = !busy && !cmd_empty_i && (!res_pend || !res_full_i);
  assign res_push_o = res_pend && !res_full_i;
  assign res_data_o = rdata_q;
  assign busy_o     = busy;

  assign mdc_o     = mdc_q;
  assign mdio_o    = busy ? frame_q[MDIO_FRAME_BITS-1] : 1'b1;  // Idle line high
  assign mdio_oe_o = busy && !(is_read && bit_cnt >= MDIO_TA_BIT);  // Release for TA + data

  // ----------------------------------------------------------
  // Bit timing and frame control
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      busy     <= 1'b0;
      mdc_q    <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      res_pend <= 1'b0;
    end else begin
      if (cmd_pop_o) begin  // Frame starts next cycle with MDC low
        busy    <= 1'b1;
        div_cnt <= '0;
        bit_cnt <= '0;
      end else if (busy) begin
        div_cnt <= (div_cnt == MDC_LAST_CNT) ? '0 : div_cnt + 1'b1;
        if (div_cnt == MDC_RISE_CNT) mdc_q <= 1'b1;  // PHY samples here
        if (div_cnt == MDC_LAST_CNT) begin
          mdc_q <= 1'b0;  // Falling edge, next bit goes out
          if (bit_cnt == MDIO_LAST_BIT) begin
            busy     <= 1'b0;
            res_pend <= is_read;  // Only reads return data
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      end
      if (res_push_o) res_pend <= 1'b0;
    end
  end

  // Shift registers
  always_ff @(posedge bus_clk) begin
    if (cmd_pop_o) begin
      frame_q <= frame_d;
      is_read <= (cmd_data_i.op == READ);
    end else if (busy && div_cnt == MDC_LAST_CNT) begin
      frame_q <= {frame_q[MDIO_FRAME_BITS-2:0], 1'b0};
    end
    // Read data sampled with the MDC rising edge
    if (busy && is_read && div_cnt == MDC_RISE_CNT && bit_cnt >= MDIO_DATA_BIT)
      rdata_q <= {rdata_q[14:0], mdio_i};
  end

  // MDC is parked while idle, frames end with MDC low
  a_mdc_idle : assert property (@(posedge bus_clk) disable iff (bus_rst)
    !busy_o |-> !mdc_o);

endmodule

/* source/mdio_cmd_fifo.sv */
`timescale 1ns/1ps

module mdio_cmd_fifo #(
  parameter type payload_t = logic [15:0]
) (
  input  logic     bus_clk,
  input  logic     bus_rst,
  input  logic     push_i,
  input  payload_t push_data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t pop_data_o,
  output logic     empty_o
);
  import mdio_pkg::*;

  payload_t                mem [MDIO_FIFO_DEPTH];  // Storage, no reset needed
  logic [MDIO_FIFO_AW-1:0] wr_ptr;
  logic [MDIO_FIFO_AW-1:0] rd_ptr;
  logic [MDIO_FIFO_AW:0]   count;  // One extra bit to tell full from empty
  logic                    do_push;
  logic                    do_pop;

  assign full_o     = (count == (MDIO_FIFO_AW + 1)'(MDIO_FIFO_DEPTH));
  assign empty_o    = (count == '0);
  assign pop_data_o = mem[rd_ptr];  // Head is visible while not empty

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)  // Wrap at depth, not at power of two
        wr_ptr <= (wr_ptr == MDIO_FIFO_AW'(MDIO_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == MDIO_FIFO_AW'(MDIO_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge bus_clk) begin
    if (do_push) mem[wr_ptr] <= push_data_i;
  end

  // Producer and consumer must respect the flags
  a_no_push_full : assert property (@(posedge bus_clk) disable iff (bus_rst)
    push_i |-> !full_o);
  a_no_pop_empty : assert property (@(posedge bus_clk) disable iff (bus_rst)
    pop_i |-> !empty_o);

endmodule

/* source/mdio_pkg.sv */
package mdio_pkg;

  // ----------------------------------------------------------
  // Command and result types
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    WRITE = 2'b01,
    READ  = 2'b10
  } mdio_op_e;

  // Same layout as MDIO_CMD bits 27:0
  typedef struct packed {
    mdio_op_e    op;     // 27:26
    logic [4:0]  phyad;  // 25:21
    logic [4:0]  regad;  // 20:16
    logic [15:0] wdata;  // 15:0, ignored for reads
  } mdio_cmd_t;

  typedef logic [15:0] mdio_rdata_t;

  // ----------------------------------------------------------
  // Frame geometry, bit indices counted from the first bit sent
  // ----------------------------------------------------------
  localparam int MDIO_FRAME_BITS = 64;  // 32 preamble + 32 frame
  localparam int MDIO_BIT_W      = $clog2(MDIO_FRAME_BITS);
  localparam logic [MDIO_BIT_W-1:0] MDIO_TA_BIT   = MDIO_BIT_W'(46);  // Turnaround start
  localparam logic [MDIO_BIT_W-1:0] MDIO_DATA_BIT = MDIO_BIT_W'(48);  // First data bit
  localparam logic [MDIO_BIT_W-1:0] MDIO_LAST_BIT = MDIO_BIT_W'(MDIO_FRAME_BITS - 1);

  typedef logic [MDIO_FRAME_BITS-1:0] mdio_frame_t;

  // MDC divider, bus_clk cycles per half period
  localparam int MDC_HALF  = 4;
  localparam int MDC_CNT_W = $clog2(2 * MDC_HALF);
  localparam logic [MDC_CNT_W-1:0] MDC_RISE_CNT = MDC_CNT_W'(MDC_HALF - 1);
  localparam logic [MDC_CNT_W-1:0] MDC_LAST_CNT = MDC_CNT_W'(2 * MDC_HALF - 1);

  // Command / result FIFO size
  localparam int MDIO_FIFO_DEPTH = 4;
  localparam int MDIO_FIFO_AW    = $clog2(MDIO_FIFO_DEPTH);

endpackage

/* source/sfp_regs_pkg.sv */
package sfp_regs_pkg;

  // ----------------------------------------------------------
  // Register port types
  // ----------------------------------------------------------
  typedef logic [13:0] reg_addr_t;  // Byte address on the register port
  typedef logic [31:0] reg_data_t;

  // Register map
  localparam reg_addr_t REG_MAC_CTRL    = 14'h00;  // tx_enable, MAC status
  localparam reg_addr_t REG_PHY_CTRL    = 14'h04;  // PHY reset / tx_disable, PHY status
  localparam reg_addr_t REG_MDIO_CMD    = 14'h10;  // Write only, pushes a command
  localparam reg_addr_t REG_MDIO_STATUS = 14'h14;
  localparam reg_addr_t REG_MDIO_RDATA  = 14'h18;  // Read pops one result

  // ----------------------------------------------------------
  // MAC / PHY status and control
  // ----------------------------------------------------------
  // crc_error ends up in bit 0, remote_fault in bit 8
  typedef struct packed {
    logic remote_fault;
    logic local_fault;
    logic pause_rx;
    logic rxfifo_udflow;
    logic rxfifo_ovflow;
    logic txfifo_udflow;
    logic txfifo_ovflow;
    logic fragment_error;
    logic crc_error;
  } mac_status_t;

  typedef logic [15:0] phy_status_t;  // Core status vector from the PHY

  // Matches PHY_CTRL bits 1:0
  typedef struct packed {
    logic tx_disable;  // Bit 1, to the SFP cage
    logic phy_reset;   // Bit 0
  } phy_ctrl_t;

  // Flops per status synchronizer
  localparam int SYNC_STAGES = 2;

endpackage
